/* common/mem_shim_pkg.sv */
// Memory request shim shared types

package mem_shim_pkg;

    // ========================================================
    // Sizing
    // ========================================================

    // Almost-full asserts when this many free slots or fewer remain
    localparam int alm_full_threshold = 4;

    // Two extra slots absorb requests still in flight after almost-full
    localparam int fifo_entries = alm_full_threshold + 2;

    // AFU line addresses are virtual and FIU line addresses are physical
    localparam int vaddr_bits  = 32;
    localparam int region_bits = 4;
    localparam int paddr_bits  = 44;

    // A region base supplies the physical bits above the region offset
    localparam int preg_bits = 16;

    localparam int mdata_bits = 16;
    localparam int data_bits  = 64;

    // ========================================================
    // AFU side requests
    // ========================================================

    // Read header on channel 0
    typedef struct packed {
        logic [vaddr_bits-1:0] addr;
        logic [mdata_bits-1:0] mdata;
    } t_c0_req;

    typedef struct packed {
        logic    valid;
        t_c0_req hdr;
    } t_c0_tx;

    // Channel 1 header views, mdata sits in the low bits of both
    typedef struct packed {
        logic [vaddr_bits-1:0] addr;
        logic [mdata_bits-1:0] mdata;
    } t_c1_wr_hdr;

    typedef struct packed {
        logic [15:0]            vector;
        logic [vaddr_bits-17:0] pad;
        logic [mdata_bits-1:0]  mdata;
    } t_c1_intr_hdr;

    // One header word, decoded as a write or as an interrupt
    typedef union packed {
        t_c1_wr_hdr   wr;
        t_c1_intr_hdr intr;
    } t_c1_body;

    typedef struct packed {
        logic                 is_intr;
        t_c1_body             body;
        logic [data_bits-1:0] data;
    } t_c1_req;

    typedef struct packed {
        logic    valid;
        t_c1_req req;
    } t_c1_tx;

    // ========================================================
    // FIU side requests
    // ========================================================

    typedef struct packed {
        logic                  valid;
        logic [paddr_bits-1:0] addr;
        logic [mdata_bits-1:0] mdata;
    } t_fiu_c0_tx;

    typedef struct packed {
        logic [paddr_bits-1:0] addr;
        logic [mdata_bits-1:0] mdata;
    } t_fiu_c1_wr_hdr;

    typedef struct packed {
        logic [15:0]            vector;
        logic [paddr_bits-17:0] pad;
        logic [mdata_bits-1:0]  mdata;
    } t_fiu_c1_intr_hdr;

    typedef union packed {
        t_fiu_c1_wr_hdr   wr;
        t_fiu_c1_intr_hdr intr;
    } t_fiu_c1_body;

    typedef struct packed {
        logic                 valid;
        logic                 is_intr;
        t_fiu_c1_body         body;
        logic [data_bits-1:0] data;
    } t_fiu_c1_tx;

    // ========================================================
    // Responses and configuration
    // ========================================================

    typedef struct packed {
        logic                  valid;
        logic [mdata_bits-1:0] mdata;
        logic [data_bits-1:0]  data;
    } t_c0_rx;

    typedef struct packed {
        logic                  valid;
        logic [mdata_bits-1:0] mdata;
    } t_c1_rx;

    // A strobe writes one region base of the translation table
    typedef struct packed {
        logic                   strobe;
        logic [region_bits-1:0] region;
        logic [preg_bits-1:0]   base;
    } t_xlate_cfg;

endpackage

/* buffer/req_fifo.sv */
// Request FIFO with almost-full
`timescale 1ns/10ps

module req_fifo
#(
    parameter int n_data_bits = 32
)
(
    input  logic                   clk,
    input  logic                   rst,

    input  logic [n_data_bits-1:0] enq_data,
    input  logic                   enq_en,

    output logic [n_data_bits-1:0] first,
    input  logic                   deq_en,
    output logic                   not_empty,
    output logic                   alm_full
);

    // Circular storage indexed by the read and write pointers
    logic [n_data_bits-1:0] mem [mem_shim_pkg::fifo_entries];

    logic [$clog2(mem_shim_pkg::fifo_entries)-1:0]   wr_ptr;
    logic [$clog2(mem_shim_pkg::fifo_entries)-1:0]   rd_ptr;
    logic [$clog2(mem_shim_pkg::fifo_entries+1)-1:0] count;
    logic [$clog2(mem_shim_pkg::fifo_entries+1)-1:0] count_next;
    logic                                            do_deq;

    // Pointers wrap at the depth, which need not be a power of two
    function automatic logic [$clog2(mem_shim_pkg::fifo_entries)-1:0] ptr_inc(
        input logic [$clog2(mem_shim_pkg::fifo_entries)-1:0] ptr
    );
        if (ptr == mem_shim_pkg::fifo_entries - 1)
        begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // The oldest entry is always visible at the head
    assign first     = mem[rd_ptr];
    assign not_empty = (count != '0);

    // A dequeue of an empty FIFO is ignored
    assign do_deq = deq_en && not_empty;

    always_comb
    begin
        count_next = count;
        if (enq_en && !do_deq)
        begin
            count_next = count + 1'b1;
        end
        else if (!enq_en && do_deq)
        begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            mem[wr_ptr] <= enq_data;
        end
    end

    // Almost-full is computed from the next occupancy so it is registered
    // yet still current in the cycle after the update
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            alm_full <= 1'b0;
        end
        else
        begin
            if (enq_en)
            begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_deq)
            begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count    <= count_next;
            alm_full <= (mem_shim_pkg::fifo_entries - count_next) <=
                        mem_shim_pkg::alm_full_threshold;
        end
    end

endmodule

/* buffer/afu_req_buffer.sv */
// AFU side request buffer
`timescale 1ns/10ps

module afu_req_buffer
#(
    // Nonzero lets a channel 0 request skip the empty FIFO when it is
    // consumed in the cycle it arrives
    parameter bit enable_c0_bypass = 1'b0
)
(
    input  logic                 clk,
    input  logic                 rst,

    // Raw requests from the AFU
    input  mem_shim_pkg::t_c0_tx afu_c0,
    input  mem_shim_pkg::t_c1_tx afu_c1,
    output logic                 c0_alm_full,
    output logic                 c1_alm_full,

    // Buffered heads, consumed only by an explicit dequeue
    output mem_shim_pkg::t_c0_tx buf_c0,
    output mem_shim_pkg::t_c1_tx buf_c1,
    input  logic                 deq_c0,
    input  logic                 deq_c1
);

    // ========================================================
    // Channel 0 read requests
    // ========================================================

    mem_shim_pkg::t_c0_req c0_first;
    logic                  c0_not_empty;
    logic                  c0_enq;
    logic                  c0_deq;

    generate
        if (enable_c0_bypass)
        begin : g_c0_bypass
            // The FIFO head has priority so order is kept
            // When the FIFO is empty the raw request is offered directly
            always_comb
            begin
                if (c0_not_empty)
                begin
                    buf_c0.valid = 1'b1;
                    buf_c0.hdr   = c0_first;
                end
                else
                begin
                    buf_c0 = afu_c0;
                end
            end

            // A new request is stored unless it left through the bypass
            assign c0_enq = afu_c0.valid && (c0_not_empty || !deq_c0);
            assign c0_deq = deq_c0 && c0_not_empty;
        end
        else
        begin : g_c0_no_bypass
            // Every request passes through the FIFO
            assign buf_c0.valid = c0_not_empty;
            assign buf_c0.hdr   = c0_first;
            assign c0_enq       = afu_c0.valid;
            assign c0_deq       = deq_c0;
        end
    endgenerate

    req_fifo
    #(
        .n_data_bits($bits(mem_shim_pkg::t_c0_req))
    )
    u_c0_fifo
    (
        .clk       (clk),
        .rst       (rst),
        .enq_data  (afu_c0.hdr),
        .enq_en    (c0_enq),
        .first     (c0_first),
        .deq_en    (c0_deq),
        .not_empty (c0_not_empty),
        .alm_full  (c0_alm_full)
    );

    // ========================================================
    // Channel 1 write and interrupt requests
    // ========================================================

    mem_shim_pkg::t_c1_req c1_first;
    logic                  c1_not_empty;

    // No bypass here, a mux on the line data costs too much
    // The head is only valid while the FIFO holds something
    assign buf_c1.valid = c1_not_empty;
    assign buf_c1.req   = c1_first;

    req_fifo
    #(
        .n_data_bits($bits(mem_shim_pkg::t_c1_req))
    )
    u_c1_fifo
    (
        .clk       (clk),
        .rst       (rst),
        .enq_data  (afu_c1.req),
        .enq_en    (afu_c1.valid),
        .first     (c1_first),
        .deq_en    (deq_c1),
        .not_empty (c1_not_empty),
        .alm_full  (c1_alm_full)
    );

endmodule

/* design/region_xlate_shim.sv */
// Region address translation shim
`timescale 1ns/10ps

module region_xlate_shim
(
    input  logic                     clk,
    input  logic                     rst,

    // Table write port, one entry per strobe
    input  mem_shim_pkg::t_xlate_cfg cfg,

    // Heads of the request buffer
    input  mem_shim_pkg::t_c0_tx     buf_c0,
    input  mem_shim_pkg::t_c1_tx     buf_c1,
    output logic                     deq_c0,
    output logic                     deq_c1,

    // Requests toward the FIU
    input  logic                     fiu_c0_alm_full,
    input  logic                     fiu_c1_alm_full,
    output mem_shim_pkg::t_fiu_c0_tx fiu_c0,
    output mem_shim_pkg::t_fiu_c1_tx fiu_c1
);

    // ========================================================
    // Translation table
    // ========================================================

    // One physical base per region, indexed by the top address bits
    logic [mem_shim_pkg::preg_bits-1:0] region_base [2**mem_shim_pkg::region_bits];

    // Reset loads the identity map so every region has a mapping
    // A strobe lands at the clock edge, so a request issued in the same
    // cycle still sees the old base
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 2**mem_shim_pkg::region_bits; i++)
            begin
                region_base[i] <= (mem_shim_pkg::preg_bits)'(i);
            end
        end
        else if (cfg.strobe)
        begin
            region_base[cfg.region] <= cfg.base;
        end
    end

    // Physical address is the region base followed by the region offset
    function automatic logic [mem_shim_pkg::paddr_bits-1:0] xlate(
        input logic [mem_shim_pkg::vaddr_bits-1:0] vaddr
    );
        return {region_base[vaddr[mem_shim_pkg::vaddr_bits-1 -: mem_shim_pkg::region_bits]],
                vaddr[mem_shim_pkg::vaddr_bits-mem_shim_pkg::region_bits-1:0]};
    endfunction

    // ========================================================
    // Dequeue control
    // ========================================================

    // A head moves on only if the FIU can take another request
    assign deq_c0 = buf_c0.valid && !fiu_c0_alm_full;
    assign deq_c1 = buf_c1.valid && !fiu_c1_alm_full;

    // ========================================================
    // Channel 1 header decode
    // ========================================================

    mem_shim_pkg::t_fiu_c1_body c1_body_xl;

    // The is_intr bit selects which view of the header word applies
    always_comb
    begin
        c1_body_xl = '0;
        if (buf_c1.req.is_intr)
        begin
            // Interrupts carry no address, vector and tag pass through
            c1_body_xl.intr.vector = buf_c1.req.body.intr.vector;
            c1_body_xl.intr.mdata  = buf_c1.req.body.intr.mdata;
        end
        else
        begin
            c1_body_xl.wr.addr  = xlate(buf_c1.req.body.wr.addr);
            c1_body_xl.wr.mdata = buf_c1.req.body.wr.mdata;
        end
    end

    // ========================================================
    // FIU issue registers
    // ========================================================

    // Payload loads on a dequeue and the valid bits follow the dequeues
    always_ff @(posedge clk)
    begin
        if (deq_c0)
        begin
            fiu_c0.addr  <= xlate(buf_c0.hdr.addr);
            fiu_c0.mdata <= buf_c0.hdr.mdata;
        end
        if (deq_c1)
        begin
            fiu_c1.is_intr <= buf_c1.req.is_intr;
            fiu_c1.body    <= c1_body_xl;
            fiu_c1.data    <= buf_c1.req.data;
        end

        if (rst)
        begin
            fiu_c0.valid <= 1'b0;
            fiu_c1.valid <= 1'b0;
        end
        else
        begin
            fiu_c0.valid <= deq_c0;
            fiu_c1.valid <= deq_c1;
        end
    end

endmodule

/* design/mem_shim_top.sv */
// Memory request shim top level
`timescale 1ns/10ps

module mem_shim_top
(
    input  logic                     clk,
    input  logic                     rst,

    // Translation table configuration
    input  mem_shim_pkg::t_xlate_cfg cfg,

    // AFU facing requests and responses
    input  mem_shim_pkg::t_c0_tx     afu_c0,
    input  mem_shim_pkg::t_c1_tx     afu_c1,
    output logic                     c0_alm_full,
    output logic                     c1_alm_full,
    output mem_shim_pkg::t_c0_rx     afu_c0_rx,
    output mem_shim_pkg::t_c1_rx     afu_c1_rx,

    // FIU facing requests and responses
    output mem_shim_pkg::t_fiu_c0_tx fiu_c0,
    output mem_shim_pkg::t_fiu_c1_tx fiu_c1,
    input  logic                     fiu_c0_alm_full,
    input  logic                     fiu_c1_alm_full,
    input  mem_shim_pkg::t_c0_rx     fiu_c0_rx,
    input  mem_shim_pkg::t_c1_rx     fiu_c1_rx
);

    mem_shim_pkg::t_c0_tx buf_c0;
    mem_shim_pkg::t_c1_tx buf_c1;
    logic                 deq_c0;
    logic                 deq_c1;

    // Responses have no back-pressure and go straight to the AFU
    assign afu_c0_rx = fiu_c0_rx;
    assign afu_c1_rx = fiu_c1_rx;

    // Bypass keeps the read path at one cycle when idle
    afu_req_buffer
    #(
        .enable_c0_bypass(1'b1)
    )
    u_buffer
    (
        .clk         (clk),
        .rst         (rst),
        .afu_c0      (afu_c0),
        .afu_c1      (afu_c1),
        .c0_alm_full (c0_alm_full),
        .c1_alm_full (c1_alm_full),
        .buf_c0      (buf_c0),
        .buf_c1      (buf_c1),
        .deq_c0      (deq_c0),
        .deq_c1      (deq_c1)
    );

    region_xlate_shim u_xlate
    (
        .clk             (clk),
        .rst             (rst),
        .cfg             (cfg),
        .buf_c0          (buf_c0),
        .buf_c1          (buf_c1),
        .deq_c0          (deq_c0),
        .deq_c1          (deq_c1),
        .fiu_c0_alm_full (fiu_c0_alm_full),
        .fiu_c1_alm_full (fiu_c1_alm_full),
        .fiu_c0          (fiu_c0),
        .fiu_c1          (fiu_c1)
    );

endmodule

/* verification/mem_shim_tb.sv */
// Memory request shim testbench
`timescale 1ns/10ps

module mem_shim_tb;

    // Width of the region offset, which is never translated
    localparam int off_bits    = mem_shim_pkg::vaddr_bits - mem_shim_pkg::region_bits;
    localparam int cycle_limit = 400;

    logic                     clk = 1'b0;
    logic                     rst;
    mem_shim_pkg::t_xlate_cfg cfg;
    mem_shim_pkg::t_c0_tx     afu_c0;
    mem_shim_pkg::t_c1_tx     afu_c1;
    logic                     c0_alm_full;
    logic                     c1_alm_full;
    mem_shim_pkg::t_c0_rx     afu_c0_rx;
    mem_shim_pkg::t_c1_rx     afu_c1_rx;
    mem_shim_pkg::t_fiu_c0_tx fiu_c0;
    mem_shim_pkg::t_fiu_c1_tx fiu_c1;
    logic                     fiu_c0_alm_full;
    logic                     fiu_c1_alm_full;
    mem_shim_pkg::t_c0_rx     fiu_c0_rx;
    mem_shim_pkg::t_c1_rx     fiu_c1_rx;

    integer seed = 32'h42dd_ca1d;

    // Model copy of the region table that follows every strobe
    logic [mem_shim_pkg::preg_bits-1:0] model_table [2**mem_shim_pkg::region_bits];

    // Expected FIU requests in issue order with one queue per channel
    mem_shim_pkg::t_fiu_c0_tx exp_c0 [$];
    mem_shim_pkg::t_fiu_c1_tx exp_c1 [$];

    always #2 clk = ~clk;

    mem_shim_top u_dut
    (
        .clk             (clk),
        .rst             (rst),
        .cfg             (cfg),
        .afu_c0          (afu_c0),
        .afu_c1          (afu_c1),
        .c0_alm_full     (c0_alm_full),
        .c1_alm_full     (c1_alm_full),
        .afu_c0_rx       (afu_c0_rx),
        .afu_c1_rx       (afu_c1_rx),
        .fiu_c0          (fiu_c0),
        .fiu_c1          (fiu_c1),
        .fiu_c0_alm_full (fiu_c0_alm_full),
        .fiu_c1_alm_full (fiu_c1_alm_full),
        .fiu_c0_rx       (fiu_c0_rx),
        .fiu_c1_rx       (fiu_c1_rx)
    );

    // ==========================================================
    // Reference model
    // ==========================================================

    // Region base from the model table in front of the untouched offset
    function automatic logic [mem_shim_pkg::paddr_bits-1:0] map_addr(
        input logic [mem_shim_pkg::vaddr_bits-1:0] vaddr
    );
        logic [mem_shim_pkg::region_bits-1:0] region;
        region = (mem_shim_pkg::region_bits)'(vaddr >> off_bits);
        return {model_table[region], vaddr[off_bits-1:0]};
    endfunction

    function automatic mem_shim_pkg::t_fiu_c0_tx expect_c0(input mem_shim_pkg::t_c0_req req);
        mem_shim_pkg::t_fiu_c0_tx fiu;
        fiu.valid = 1'b1;
        fiu.addr  = map_addr(req.addr);
        fiu.mdata = req.mdata;
        return fiu;
    endfunction

    // Interrupts keep vector and tag while writes get a physical address
    function automatic mem_shim_pkg::t_fiu_c1_tx expect_c1(input mem_shim_pkg::t_c1_req req);
        mem_shim_pkg::t_fiu_c1_tx fiu;
        fiu         = '0;
        fiu.valid   = 1'b1;
        fiu.is_intr = req.is_intr;
        fiu.data    = req.data;
        if (req.is_intr)
        begin
            fiu.body.intr.vector = req.body.intr.vector;
            fiu.body.intr.mdata  = req.body.intr.mdata;
        end
        else
        begin
            fiu.body.wr.addr  = map_addr(req.body.wr.addr);
            fiu.body.wr.mdata = req.body.wr.mdata;
        end
        return fiu;
    endfunction

    // ==========================================================
    // Error reporting
    // ==========================================================

    task automatic flag_mismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    // ==========================================================
    // Checking processes
    // ==========================================================

    // FIU outputs are registered, so they are stable at the falling edge
    always @(negedge clk)
    begin : compare_fiu
        mem_shim_pkg::t_fiu_c0_tx want0;
        mem_shim_pkg::t_fiu_c1_tx want1;
        if (!rst && fiu_c0.valid)
        begin
            assert (exp_c0.size() > 0)
            else abort_run("A channel 0 request reached the FIU that was never sent");
            want0 = exp_c0.pop_front();
            assert (fiu_c0.addr == want0.addr && fiu_c0.mdata == want0.mdata)
            else flag_mismatch($sformatf("c0 got addr %h mdata %h, expected addr %h mdata %h",
                fiu_c0.addr, fiu_c0.mdata, want0.addr, want0.mdata));
        end
        if (!rst && fiu_c1.valid)
        begin
            assert (exp_c1.size() > 0)
            else abort_run("A channel 1 request reached the FIU that was never sent");
            want1 = exp_c1.pop_front();
            assert (fiu_c1.is_intr == want1.is_intr && fiu_c1.data == want1.data)
            else flag_mismatch($sformatf("c1 got is_intr %b data %h, expected is_intr %b data %h",
                fiu_c1.is_intr, fiu_c1.data, want1.is_intr, want1.data));
            // The header word is checked through the view its kind selects
            if (want1.is_intr)
            begin
                assert (fiu_c1.body.intr.vector == want1.body.intr.vector &&
                        fiu_c1.body.intr.mdata == want1.body.intr.mdata)
                else flag_mismatch($sformatf("interrupt got vector %h, expected %h",
                    fiu_c1.body.intr.vector, want1.body.intr.vector));
            end
            else
            begin
                assert (fiu_c1.body.wr.addr == want1.body.wr.addr &&
                        fiu_c1.body.wr.mdata == want1.body.wr.mdata)
                else flag_mismatch($sformatf("write got addr %h, expected %h",
                    fiu_c1.body.wr.addr, want1.body.wr.addr));
            end
        end
    end

    // Rx structs pass straight through and their inputs are settled at the rising edge
    always @(posedge clk)
    begin
        assert (afu_c0_rx == fiu_c0_rx && afu_c1_rx == fiu_c1_rx)
        else flag_mismatch("Rx response changed on its way to the AFU");
    end

    // ==========================================================
    // Stimulus
    // ==========================================================

    // Every cycle of stimulus starts here with fresh random Rx traffic
    task automatic step_cycle();
        @(negedge clk);
        fiu_c0_rx.valid = 1'($random(seed));
        fiu_c0_rx.mdata = (mem_shim_pkg::mdata_bits)'($random(seed));
        fiu_c0_rx.data  = {$random(seed), $random(seed)};
        fiu_c1_rx.valid = 1'($random(seed));
        fiu_c1_rx.mdata = (mem_shim_pkg::mdata_bits)'($random(seed));
    endtask

    function automatic mem_shim_pkg::t_c0_req random_read();
        mem_shim_pkg::t_c0_req req;
        req.addr  = $random(seed);
        req.mdata = (mem_shim_pkg::mdata_bits)'($random(seed));
        return req;
    endfunction

    function automatic mem_shim_pkg::t_c1_req random_c1(input bit intr);
        mem_shim_pkg::t_c1_req req;
        req.is_intr = intr;
        req.data    = {$random(seed), $random(seed)};
        if (intr)
        begin
            req.body.intr.vector = 16'($random(seed));
            req.body.intr.pad    = '0;
            req.body.intr.mdata  = (mem_shim_pkg::mdata_bits)'($random(seed));
        end
        else
        begin
            req.body.wr.addr  = $random(seed);
            req.body.wr.mdata = (mem_shim_pkg::mdata_bits)'($random(seed));
        end
        return req;
    endfunction

    // Table writes happen only while the path is idle
    task automatic write_region(
        input logic [mem_shim_pkg::region_bits-1:0] region,
        input logic [mem_shim_pkg::preg_bits-1:0]   base
    );
        step_cycle();
        cfg.strobe          = 1'b1;
        cfg.region          = region;
        cfg.base            = base;
        model_table[region] = base;
        step_cycle();
        cfg = '0;
    endtask

    // A single read into an idle path shows up at the FIU one cycle later
    task automatic check_read_latency();
        step_cycle();
        afu_c0.valid = 1'b1;
        afu_c0.hdr   = random_read();
        exp_c0.push_back(expect_c0(afu_c0.hdr));
        step_cycle();
        afu_c0 = '0;
        assert (fiu_c0.valid)
        else flag_mismatch("Read did not reach the FIU one cycle after entering an idle path");
    endtask

    // Random requests on both channels that obey the AFU almost-full signals
    task automatic run_traffic(input int n_c0, input int n_c1, input bit intr, input bit stall);
        int sent0;
        int sent1;
        int cycles;
        sent0  = 0;
        sent1  = 0;
        cycles = 0;
        while (sent0 < n_c0 || sent1 < n_c1)
        begin
            step_cycle();
            cycles++;
            if (cycles > cycle_limit)
            begin
                abort_run("Timeout while sending requests, almost-full never dropped");
            end
            fiu_c0_alm_full = stall && (($random(seed) & 3) == 0);
            fiu_c1_alm_full = stall && (($random(seed) & 3) == 0);
            afu_c0 = '0;
            afu_c1 = '0;
            if (sent0 < n_c0 && !c0_alm_full && ($random(seed) & 1))
            begin
                afu_c0.valid = 1'b1;
                afu_c0.hdr   = random_read();
                exp_c0.push_back(expect_c0(afu_c0.hdr));
                sent0++;
            end
            if (sent1 < n_c1 && !c1_alm_full && ($random(seed) & 1))
            begin
                afu_c1.valid = 1'b1;
                afu_c1.req   = random_c1(intr && (($random(seed) & 3) == 0));
                exp_c1.push_back(expect_c1(afu_c1.req));
                sent1++;
            end
        end
    endtask

    // Releases all stalls and waits until every expected request came out
    task automatic wait_drain();
        int cycles;
        cycles = 0;
        do
        begin
            step_cycle();
            afu_c0          = '0;
            afu_c1          = '0;
            fiu_c0_alm_full = 1'b0;
            fiu_c1_alm_full = 1'b0;
            cycles++;
            if (cycles > cycle_limit)
            begin
                abort_run("Timeout while waiting for queued requests to reach the FIU");
            end
        end
        while (exp_c0.size() != 0 || exp_c1.size() != 0);
        step_cycle();
    endtask

    // FIU back-pressure fills both buffers until the AFU is told to stop
    task automatic hold_fiu();
        int cycles;
        cycles = 0;
        step_cycle();
        fiu_c0_alm_full = 1'b1;
        fiu_c1_alm_full = 1'b1;
        while (!(c0_alm_full && c1_alm_full) || cycles < 8)
        begin
            step_cycle();
            cycles++;
            if (cycles > cycle_limit)
            begin
                abort_run("Timeout while waiting for both AFU almost-full signals");
            end
            assert (!fiu_c0.valid && !fiu_c1.valid)
            else flag_mismatch("FIU valid asserted while FIU almost-full was held high");
            afu_c0 = '0;
            afu_c1 = '0;
            if (!c0_alm_full)
            begin
                afu_c0.valid = 1'b1;
                afu_c0.hdr   = random_read();
                exp_c0.push_back(expect_c0(afu_c0.hdr));
            end
            if (!c1_alm_full)
            begin
                afu_c1.valid = 1'b1;
                afu_c1.req   = random_c1(($random(seed) & 1) == 1);
                exp_c1.push_back(expect_c1(afu_c1.req));
            end
        end
    endtask

    initial
    begin : stimulus
        rst             = 1'b1;
        cfg             = '0;
        afu_c0          = '0;
        afu_c1          = '0;
        fiu_c0_alm_full = 1'b0;
        fiu_c1_alm_full = 1'b0;
        fiu_c0_rx       = '0;
        fiu_c1_rx       = '0;
        for (int i = 0; i < 2**mem_shim_pkg::region_bits; i++)
        begin
            model_table[i] = (mem_shim_pkg::preg_bits)'(i);
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        assert (!c0_alm_full && !c1_alm_full && !fiu_c0.valid && !fiu_c1.valid)
        else flag_mismatch("Outputs not idle after reset");

        // Identity map, single reads and then a stream of reads
        for (int i = 0; i < 8; i++)
        begin
            check_read_latency();
        end
        run_traffic(40, 0, 1'b0, 1'b1);
        wait_drain();

        // Remapped regions on both channels
        for (int i = 0; i < 6; i++)
        begin
            write_region((mem_shim_pkg::region_bits)'($random(seed)),
                         (mem_shim_pkg::preg_bits)'($random(seed)));
        end
        run_traffic(60, 60, 1'b0, 1'b1);
        wait_drain();

        // Writes mixed with interrupts
        run_traffic(0, 80, 1'b1, 1'b1);
        wait_drain();

        // Full back-pressure followed by release
        hold_fiu();
        wait_drain();
        run_traffic(100, 100, 1'b1, 1'b1);
        wait_drain();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* mem_shim.f */
common/mem_shim_pkg.sv
buffer/req_fifo.sv
buffer/afu_req_buffer.sv
design/region_xlate_shim.sv
design/mem_shim_top.sv
verification/mem_shim_tb.sv

/* Bender.yml */
package:
  name: mem_shim

sources:
  # Shared package
  - files:
      - common/mem_shim_pkg.sv

  # RTL in compile order
  - files:
      - buffer/req_fifo.sv
      - buffer/afu_req_buffer.sv
      - design/region_xlate_shim.sv
      - design/mem_shim_top.sv

  # Testbench
  - target: test
    files:
      - verification/mem_shim_tb.sv
